// ==== Makefile ====
# Verilator build, run and lint for the reservation station

VERILATOR  := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_reservation_station
RTL_TOP    := reservation_station
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/rs_defines.svh ====
/*
 * Reservation station sizing macros: entry count, tag, operand, age and
 * register index widths, and the tag value that means no producer.
 */

`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// station depth
`define RS_NUM_ENTRIES 8

// field widths
`define RS_TAG_W   8
`define RS_VALUE_W 64
`define RS_AGE_W   8
`define RS_REG_W   5

// all ones on a tag means the operand is final, and on the CDB that no
// result is being broadcast
`define RS_TAG_NULL ({`RS_TAG_W{1'b1}})

`endif

// ==== src/reservation_station.sv ====
/*
 * Eight-entry reservation station top level: dispatch bundle, select
 * logic and the entry array, single dispatch, single CDB, single issue.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module reservation_station
   import rs_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   // dispatch
   input  logic       dispatch_valid,
   input  rs_tag_t    rega_tag,
   input  rs_tag_t    regb_tag,
   input  rs_value_t  rega_value,
   input  rs_value_t  regb_value,
   input  rs_reg_t    dest_reg,
   input  rs_tag_t    dest_tag,
   input  logic [1:0] opa_select,
   input  logic [1:0] opb_select,
   input  logic [4:0] alu_func,
   input  logic       rd_mem,
   input  logic       wr_mem,
   input  logic       cond_branch,
   input  logic       uncond_branch,
   output logic       dispatch_ready,
   // result bus
   input  rs_tag_t    cdb_tag,
   input  rs_value_t  cdb_value,
   // issue to execute
   output logic       issue_valid,
   output rs_value_t  issue_rega_value,
   output rs_value_t  issue_regb_value,
   output rs_reg_t    issue_dest_reg,
   output rs_tag_t    issue_dest_tag,
   output logic [1:0] issue_opa_select,
   output logic [1:0] issue_opb_select,
   output logic [4:0] issue_alu_func,
   output logic       issue_rd_mem,
   output logic       issue_wr_mem,
   output logic       issue_cond_branch,
   output logic       issue_uncond_branch
);

   localparam int N = `RS_NUM_ENTRIES;

   logic [N-1:0] fill;
   logic [N-1:0] grant;
   logic [N-1:0] ready;
   logic [N-1:0] empty;
   logic         dispatch_accept;
   rs_age_t      ages        [N];
   rs_value_t    rega_values [N];
   rs_value_t    regb_values [N];
   rs_reg_t      dest_regs   [N];
   rs_tag_t      dest_tags   [N];
   rs_op_t       ops         [N];
   rs_op_t       issue_op;

   rs_dispatch_if dispatch_bus ();

   //////////////////////////////////////////////////////////////////////
   // dispatch bundle
   //////////////////////////////////////////////////////////////////////

   assign dispatch_bus.rega_tag   = rega_tag;
   assign dispatch_bus.regb_tag   = regb_tag;
   assign dispatch_bus.rega_value = rega_value;
   assign dispatch_bus.regb_value = regb_value;
   assign dispatch_bus.dest_reg   = dest_reg;
   assign dispatch_bus.dest_tag   = dest_tag;
   assign dispatch_bus.op         = '{opa_select: opa_select, opb_select: opb_select,
                                      alu_func: alu_func, rd_mem: rd_mem, wr_mem: wr_mem,
                                      cond_branch: cond_branch,
                                      uncond_branch: uncond_branch};

   //////////////////////////////////////////////////////////////////////
   // entry array
   //////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < N; i++)
   begin : g_entry
      rs_entry u_entry (
         .clock           (clock),
         .reset           (reset),
         .fill            (fill[i]),
         .grant           (grant[i]),
         .dispatch_accept (dispatch_accept),
         .dispatch        (dispatch_bus),
         .cdb_tag         (cdb_tag),
         .cdb_value       (cdb_value),
         .ready           (ready[i]),
         .empty           (empty[i]),
         .age             (ages[i]),
         .rega_value      (rega_values[i]),
         .regb_value      (regb_values[i]),
         .dest_reg        (dest_regs[i]),
         .dest_tag        (dest_tags[i]),
         .op              (ops[i])
      );
   end

   rs_select u_select (
      .dispatch_valid   (dispatch_valid),
      .ready            (ready),
      .empty            (empty),
      .ages             (ages),
      .rega_values      (rega_values),
      .regb_values      (regb_values),
      .dest_regs        (dest_regs),
      .dest_tags        (dest_tags),
      .ops              (ops),
      .fill             (fill),
      .grant            (grant),
      .dispatch_ready   (dispatch_ready),
      .dispatch_accept  (dispatch_accept),
      .issue_valid      (issue_valid),
      .issue_rega_value (issue_rega_value),
      .issue_regb_value (issue_regb_value),
      .issue_dest_reg   (issue_dest_reg),
      .issue_dest_tag   (issue_dest_tag),
      .issue_op         (issue_op)
   );

   // control fields back out as plain ports
   assign issue_opa_select    = issue_op.opa_select;
   assign issue_opb_select    = issue_op.opb_select;
   assign issue_alu_func      = issue_op.alu_func;
   assign issue_rd_mem        = issue_op.rd_mem;
   assign issue_wr_mem        = issue_op.wr_mem;
   assign issue_cond_branch   = issue_op.cond_branch;
   assign issue_uncond_branch = issue_op.uncond_branch;

endmodule

`default_nettype wire

// ==== src/rs_age_counter.sv ====
/*
 * Per-entry age: counts the dispatches accepted after this entry was
 * filled, saturating at the top of its range.
 */

`timescale 1ns/1ps
`default_nettype none

module rs_age_counter
   import rs_pkg::*;
(
   input  logic    clock,
   input  logic    reset,
   input  logic    fill,
   input  logic    dispatch_accept,
   input  logic    occupied,
   output rs_age_t age
);

   localparam rs_age_t AGE_MAX = '1;

   logic at_max;

   assign at_max = (age == AGE_MAX);

   // a fresh or idle entry is the youngest
   always_ff @(posedge clock)
   begin
      if (reset || fill || !occupied)
         age <= '0;
      else if (dispatch_accept && !at_max)
         age <= age + 1'b1;
   end

endmodule

`default_nettype wire

// ==== src/rs_dispatch_if.sv ====
/*
 * Dispatch bundle for one instruction, driven by the station top level
 * and read by every entry.
 */

`timescale 1ns/1ps
`default_nettype none

interface rs_dispatch_if;

   rs_pkg::rs_tag_t   rega_tag;
   rs_pkg::rs_tag_t   regb_tag;
   rs_pkg::rs_value_t rega_value;
   rs_pkg::rs_value_t regb_value;
   rs_pkg::rs_reg_t   dest_reg;
   rs_pkg::rs_tag_t   dest_tag;
   rs_pkg::rs_op_t    op;

   // driven from the dispatch ports
   modport source (output rega_tag, regb_tag, rega_value, regb_value,
                   output dest_reg, dest_tag, op);

   // each entry samples the bundle on its own fill strobe
   modport sink (input rega_tag, regb_tag, rega_value, regb_value,
                 input dest_reg, dest_tag, op);

endinterface

`default_nettype wire

// ==== src/rs_entry.sv ====
/*
 * One reservation station entry: status FSM, age counter, two operand
 * slots and the destination and execute control fields.
 */

`timescale 1ns/1ps
`default_nettype none

module rs_entry
   import rs_pkg::*;
(
   input  logic               clock,
   input  logic               reset,
   input  logic               fill,
   input  logic               grant,
   input  logic               dispatch_accept,
   rs_dispatch_if.sink        dispatch,
   input  rs_tag_t            cdb_tag,
   input  rs_value_t          cdb_value,
   output logic               ready,
   output logic               empty,
   output rs_age_t            age,
   output rs_value_t          rega_value,
   output rs_value_t          regb_value,
   output rs_reg_t            dest_reg,
   output rs_tag_t            dest_tag,
   output rs_op_t             op
);

   logic       wait_a;
   logic       wait_b;
   rs_status_e status;

   //////////////////////////////////////////////////////////////////////
   // source operands
   //////////////////////////////////////////////////////////////////////

   rs_operand_slot u_slot_a (
      .clock     (clock),
      .reset     (reset),
      .fill      (fill),
      .tag_in    (dispatch.rega_tag),
      .value_in  (dispatch.rega_value),
      .cdb_tag   (cdb_tag),
      .cdb_value (cdb_value),
      .waiting   (wait_a),
      .value     (rega_value)
   );

   rs_operand_slot u_slot_b (
      .clock     (clock),
      .reset     (reset),
      .fill      (fill),
      .tag_in    (dispatch.regb_tag),
      .value_in  (dispatch.regb_value),
      .cdb_tag   (cdb_tag),
      .cdb_value (cdb_value),
      .waiting   (wait_b),
      .value     (regb_value)
   );

   //////////////////////////////////////////////////////////////////////
   // status and age
   //////////////////////////////////////////////////////////////////////

   rs_entry_control u_control (
      .clock  (clock),
      .reset  (reset),
      .fill   (fill),
      .grant  (grant),
      .wait_a (wait_a),
      .wait_b (wait_b),
      .status (status),
      .ready  (ready),
      .empty  (empty)
   );

   rs_age_counter u_age (
      .clock           (clock),
      .reset           (reset),
      .fill            (fill),
      .dispatch_accept (dispatch_accept),
      .occupied        (status != RS_EMPTY),
      .age             (age)
   );

   // destination and control fields ride along to execute
   always_ff @(posedge clock)
   begin
      if (fill)
      begin
         dest_reg <= dispatch.dest_reg;
         dest_tag <= dispatch.dest_tag;
         op       <= dispatch.op;
      end
   end

endmodule

`default_nettype wire

// ==== src/rs_entry_control.sv ====
/*
 * Status FSM of one station entry: empty, waiting on one or both
 * operands, or ready to issue.
 */

`timescale 1ns/1ps
`default_nettype none

module rs_entry_control
   import rs_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  logic       fill,
   input  logic       grant,
   input  logic       wait_a,
   input  logic       wait_b,
   output rs_status_e status,
   output logic       ready,
   output logic       empty
);

   rs_status_e status_next;

   function automatic rs_status_e wait_state(input logic pend_a, input logic pend_b);
      rs_status_e state;
      unique case ({pend_a, pend_b})
         2'b00:   state = RS_READY;
         2'b10:   state = RS_WAIT_A;
         2'b01:   state = RS_WAIT_B;
         default: state = RS_WAIT_BOTH;
      endcase
      return state;
   endfunction

   always_comb
   begin
      status_next = status;
      if (grant)
         status_next = RS_EMPTY;
      else if (fill || (status != RS_EMPTY))
         status_next = wait_state(wait_a, wait_b);
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         status <= RS_EMPTY;
      else
         status <= status_next;
   end

   assign ready = (status == RS_READY);
   assign empty = (status == RS_EMPTY);

   // the picker only grants ready entries, and the free finder only fills empty ones
   a_grant_ready: assert property (@(posedge clock) disable iff (reset)
      grant |-> (status == RS_READY));
   a_fill_empty: assert property (@(posedge clock) disable iff (reset)
      fill |-> (status == RS_EMPTY));

endmodule

`default_nettype wire

// ==== src/rs_operand_slot.sv ====
/*
 * One source operand of a station entry: pending tag, operand value and
 * the CDB wakeup, including a match in the cycle the entry is filled.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs_operand_slot
   import rs_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      fill,
   input  rs_tag_t   tag_in,
   input  rs_value_t value_in,
   input  rs_tag_t   cdb_tag,
   input  rs_value_t cdb_value,
   output logic      waiting,
   output rs_value_t value
);

   rs_tag_t   tag;
   rs_tag_t   probe_tag;
   rs_tag_t   tag_next;
   rs_value_t value_next;
   logic      hit;

   // in a fill cycle the incoming tag is the one compared with the bus
   assign probe_tag = fill ? tag_in : tag;
   assign hit       = (probe_tag != `RS_TAG_NULL) && (probe_tag == cdb_tag);

   always_comb
   begin
      tag_next   = probe_tag;
      value_next = fill ? value_in : value;
      if (hit)
      begin
         tag_next   = `RS_TAG_NULL;
         value_next = cdb_value;
      end
   end

   // pending flag as it will stand after this edge
   assign waiting = (tag_next != `RS_TAG_NULL);

   always_ff @(posedge clock)
   begin
      if (reset)
         tag <= `RS_TAG_NULL;
      else
         tag <= tag_next;
   end

   always_ff @(posedge clock)
   begin
      value <= value_next;
   end

   // a resolved operand keeps its value until the entry is refilled
   a_value_hold: assert property (@(posedge clock) disable iff (reset)
      !fill && (tag == `RS_TAG_NULL) |=> $stable(value));

endmodule

`default_nettype wire

// ==== src/rs_pkg.sv ====
/*
 * Shared reservation station types: tags, operand values, ages,
 * register indices, entry status and the execute control fields.
 */

`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

   typedef logic [`RS_TAG_W-1:0]   rs_tag_t;
   typedef logic [`RS_VALUE_W-1:0] rs_value_t;
   typedef logic [`RS_AGE_W-1:0]   rs_age_t;
   typedef logic [`RS_REG_W-1:0]   rs_reg_t;

   // entry state, one code per combination of pending operands
   typedef enum logic [2:0]
   {
      RS_EMPTY     = 3'b000,
      RS_WAIT_A    = 3'b001,
      RS_WAIT_B    = 3'b010,
      RS_WAIT_BOTH = 3'b011,
      RS_READY     = 3'b100
   } rs_status_e;

   // fields carried untouched from decode to execute, 13 bits
   typedef struct packed
   {
      logic [1:0] opa_select;
      logic [1:0] opb_select;
      logic [4:0] alu_func;
      logic       rd_mem;
      logic       wr_mem;
      logic       cond_branch;
      logic       uncond_branch;
   } rs_op_t;

endpackage

`default_nettype wire

// ==== src/rs_select.sv ====
/*
 * Station select logic: lowest free entry for dispatch, oldest ready
 * entry for issue, and the issue output multiplexer.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module rs_select
   import rs_pkg::*;
(
   input  logic                       dispatch_valid,
   input  logic [`RS_NUM_ENTRIES-1:0] ready,
   input  logic [`RS_NUM_ENTRIES-1:0] empty,
   input  rs_age_t                    ages        [`RS_NUM_ENTRIES],
   input  rs_value_t                  rega_values [`RS_NUM_ENTRIES],
   input  rs_value_t                  regb_values [`RS_NUM_ENTRIES],
   input  rs_reg_t                    dest_regs   [`RS_NUM_ENTRIES],
   input  rs_tag_t                    dest_tags   [`RS_NUM_ENTRIES],
   input  rs_op_t                     ops         [`RS_NUM_ENTRIES],
   output logic [`RS_NUM_ENTRIES-1:0] fill,
   output logic [`RS_NUM_ENTRIES-1:0] grant,
   output logic                       dispatch_ready,
   output logic                       dispatch_accept,
   output logic                       issue_valid,
   output rs_value_t                  issue_rega_value,
   output rs_value_t                  issue_regb_value,
   output rs_reg_t                    issue_dest_reg,
   output rs_tag_t                    issue_dest_tag,
   output rs_op_t                     issue_op
);

   localparam int N     = `RS_NUM_ENTRIES;
   localparam int IDX_W = $clog2(N);

   logic [N-1:0]     free_onehot;
   logic [IDX_W-1:0] pick_idx;
   rs_age_t          pick_age;

   // dispatch side, lowest set bit of the empty vector
   assign free_onehot     = empty & (~empty + 1'b1);
   assign dispatch_ready  = |empty;
   assign dispatch_accept = dispatch_valid && dispatch_ready;
   assign fill            = dispatch_accept ? free_onehot : '0;

   // issue side, strictly greater age wins so ties stay with the lower index
   always_comb
   begin
      pick_idx    = '0;
      pick_age    = '0;
      issue_valid = 1'b0;
      for (int i = 0; i < N; i++)
      begin
         if (ready[i] && (!issue_valid || (ages[i] > pick_age)))
         begin
            issue_valid = 1'b1;
            pick_idx    = IDX_W'(i);
            pick_age    = ages[i];
         end
      end
   end

   assign grant = issue_valid ? (N'(1) << pick_idx) : '0;

   assign issue_rega_value = issue_valid ? rega_values[pick_idx] : '0;
   assign issue_regb_value = issue_valid ? regb_values[pick_idx] : '0;
   assign issue_dest_reg   = issue_valid ? dest_regs[pick_idx]   : '0;
   assign issue_dest_tag   = issue_valid ? dest_tags[pick_idx]   : '0;
   assign issue_op         = issue_valid ? ops[pick_idx]         : '0;

   // each entry sees at most one strobe of either kind
   always_comb
   begin
      a_fill_onehot: assert final ($onehot0(fill));
      a_grant_onehot: assert final ($onehot0(grant));
   end

endmodule

`default_nettype wire

// ==== test/rs_golden.txt ====
// kind(1 check, 2 wait for issue) dispatch_valid rega_tag regb_tag rega_value regb_value dest_reg
// dest_tag op cdb_tag cdb_value | expected: dispatch_ready issue_valid a b dest_reg dest_tag op
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
// both operands final, issue in the next cycle
1 1 ff ff 0123456789abcdef 22 03 10 0a53 ff 0     1 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     1 1 0123456789abcdef 22 03 10 0a53
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
// operand a waits on tag 20
1 1 20 ff 0 44 05 11 1001 ff 0     1 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 20 5555     1 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     1 1 5555 44 05 11 1001
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
// CDB match in the fill cycle
1 1 ff 21 66 0 07 12 0005 21 7777     1 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     1 1 66 7777 07 12 0005
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
// oldest entry sits at index 1, younger ones at 0 and 2
1 1 31 ff 0 88 08 13 0100 ff 0     1 0 0 0 0 0 0
1 1 30 ff 0 d2 09 14 0201 ff 0     1 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 31 9999     1 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     1 1 9999 88 08 13 0100
1 1 ff 30 e1 0 0a 15 0402 ff 0     1 0 0 0 0 0 0
1 1 30 30 0 0 0b 16 0803 ff 0     1 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 30 aaaa     1 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     1 1 aaaa d2 09 14 0201
1 0 ff ff 0 0 0 0 0 ff 0     1 1 e1 aaaa 0a 15 0402
1 0 ff ff 0 0 0 0 0 ff 0     1 1 aaaa aaaa 0b 16 0803
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
// fill all eight entries, each waiting on its own tag
1 1 40 ff 0 b0 10 50 0001 ff 0     1 0 0 0 0 0 0
1 1 41 ff 0 b1 11 51 0011 ff 0     1 0 0 0 0 0 0
1 1 42 ff 0 b2 12 52 0021 ff 0     1 0 0 0 0 0 0
1 1 43 ff 0 b3 13 53 0031 ff 0     1 0 0 0 0 0 0
1 1 44 ff 0 b4 14 54 0041 ff 0     1 0 0 0 0 0 0
1 1 45 ff 0 b5 15 55 0051 ff 0     1 0 0 0 0 0 0
1 1 46 ff 0 b6 16 56 0061 ff 0     1 0 0 0 0 0 0
1 1 47 ff 0 b7 17 57 0071 ff 0     1 0 0 0 0 0 0
// ninth dispatch while full is dropped
1 1 ff ff f0 f1 1f 5f 1fff ff 0     0 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 43 cccc     0 0 0 0 0 0 0
2 0 ff ff 0 0 0 0 0 ff 0     0 1 cccc b3 13 53 0031
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0
1 0 ff ff 0 0 0 0 0 ff 0     1 0 0 0 0 0 0

// ==== test/tb_reservation_station.sv ====
/*
 * Reservation station testbench: replays per-cycle dispatch and CDB
 * stimulus from a golden file and compares every output with it.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module tb_reservation_station
   import rs_pkg::*;
   ();

   // one golden record is 18 hex words laid out as in the file's column comment
   localparam int FIELDS      = 18;
   localparam int MAX_RECORDS = 64;
   localparam int WAIT_LIMIT  = 20;

   logic       clock;
   logic       reset;
   logic       dispatch_valid, dispatch_ready, issue_valid;
   rs_tag_t    rega_tag, regb_tag, dest_tag, cdb_tag, issue_dest_tag;
   rs_value_t  rega_value, regb_value, cdb_value, issue_rega_value, issue_regb_value;
   rs_reg_t    dest_reg, issue_dest_reg;
   logic [1:0] opa_select, opb_select, issue_opa_select, issue_opb_select;
   logic [4:0] alu_func, issue_alu_func;
   logic       rd_mem, wr_mem, cond_branch, uncond_branch;
   logic       issue_rd_mem, issue_wr_mem, issue_cond_branch, issue_uncond_branch;
   rs_op_t     issued_op;
   logic [63:0] golden [FIELDS*MAX_RECORDS];

   reservation_station u_reservation_station (.*);

   assign issued_op = '{opa_select: issue_opa_select, opb_select: issue_opb_select,
                        alu_func: issue_alu_func, rd_mem: issue_rd_mem,
                        wr_mem: issue_wr_mem, cond_branch: issue_cond_branch,
                        uncond_branch: issue_uncond_branch};

   always
   begin
      #4 clock = ~clock;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic drive_idle();
      dispatch_valid <= 1'b0;
      {rega_tag, regb_tag} <= {`RS_TAG_NULL, `RS_TAG_NULL};
      {rega_value, regb_value, dest_reg, dest_tag} <= '0;
      {opa_select, opb_select, alu_func} <= '0;
      {rd_mem, wr_mem, cond_branch, uncond_branch} <= '0;
      cdb_tag   <= `RS_TAG_NULL;
      cdb_value <= '0;
   endtask

   task automatic drive_record(input int base);
      rs_op_t op;
      op = golden[base+8][$bits(rs_op_t)-1:0];
      dispatch_valid <= golden[base+1][0];
      rega_tag       <= golden[base+2][`RS_TAG_W-1:0];
      regb_tag       <= golden[base+3][`RS_TAG_W-1:0];
      rega_value     <= golden[base+4];
      regb_value     <= golden[base+5];
      dest_reg       <= golden[base+6][`RS_REG_W-1:0];
      dest_tag       <= golden[base+7][`RS_TAG_W-1:0];
      opa_select     <= op.opa_select;
      opb_select     <= op.opb_select;
      alu_func       <= op.alu_func;
      rd_mem         <= op.rd_mem;
      wr_mem         <= op.wr_mem;
      cond_branch    <= op.cond_branch;
      uncond_branch  <= op.uncond_branch;
      cdb_tag        <= golden[base+9][`RS_TAG_W-1:0];
      cdb_value      <= golden[base+10];
   endtask

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bit(input string name, input logic got, input logic expected);
      if (got !== expected)
         abort_run($sformatf("error %s: got %h, expected %h", name, got, expected));
   endtask

   task automatic check_value(input string name, input rs_value_t got, input rs_value_t expected);
      if (got !== expected)
         abort_run($sformatf("error %s: got %h, expected %h", name, got, expected));
   endtask

   task automatic check_tag(input string name, input rs_tag_t got, input rs_tag_t expected);
      if (got !== expected)
         abort_run($sformatf("error %s: got %h, expected %h", name, got, expected));
   endtask

   task automatic check_reg(input string name, input rs_reg_t got, input rs_reg_t expected);
      if (got !== expected)
         abort_run($sformatf("error %s: got %h, expected %h", name, got, expected));
   endtask

   task automatic check_op(input string name, input rs_op_t got, input rs_op_t expected);
      if (got !== expected)
         abort_run($sformatf("error %s: got %h, expected %h", name, got, expected));
   endtask

   task automatic check_record(input int base);
      check_bit("dispatch_ready", dispatch_ready, golden[base+11][0]);
      check_bit("issue_valid", issue_valid, golden[base+12][0]);
      check_value("issue_rega_value", issue_rega_value, golden[base+13]);
      check_value("issue_regb_value", issue_regb_value, golden[base+14]);
      check_reg("issue_dest_reg", issue_dest_reg, golden[base+15][`RS_REG_W-1:0]);
      check_tag("issue_dest_tag", issue_dest_tag, golden[base+16][`RS_TAG_W-1:0]);
      check_op("issue_op", issued_op, golden[base+17][$bits(rs_op_t)-1:0]);
   endtask

   // idle cycles until something issues, sampled at the falling edge
   task automatic wait_for_issue(output int cycles);
      cycles = 0;
      while (!issue_valid)
      begin
         if (cycles == WAIT_LIMIT)
            abort_run($sformatf("timeout: no issue within %0d cycles", WAIT_LIMIT));
         else
         begin
            cycles++;
            @(posedge clock);
            drive_idle();
            @(negedge clock);
         end
      end
   endtask

   initial
   begin
      int records;
      int base;
      int late;
      clock = 1'b0;
      reset = 1'b1;
      drive_idle();
      for (int i = 0; i < FIELDS*MAX_RECORDS; i++)
         golden[i] = '0;
      $readmemh("test/rs_golden.txt", golden);
      // a record with kind zero ends the list
      records = 0;
      while ((records < MAX_RECORDS) && (golden[records*FIELDS] != 0))
         records++;
      if (records == 0)
         abort_run("no stimulus records could be read from test/rs_golden.txt");
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      for (int r = 0; r < records; r++)
      begin
         base = r * FIELDS;
         @(posedge clock);
         drive_record(base);
         @(negedge clock);
         // the golden cycle is the one where the issue must already show
         if (golden[base][1:0] == 2'd2)
         begin
            wait_for_issue(late);
            if (late != 0)
               abort_run($sformatf("issue came %0d cycles later than expected", late));
         end
         check_record(base);
      end
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/rs_pkg.sv
src/rs_dispatch_if.sv
src/rs_operand_slot.sv
src/rs_entry_control.sv
src/rs_age_counter.sv
src/rs_entry.sv
src/rs_select.sv
src/reservation_station.sv
test/tb_reservation_station.sv
